// File: Makefile
SIM      := verilator
TOP      := tb_tcp_rx
FILELIST := tb.f
FLAGS    := --binary --timing --assert -j 0 --top-module $(TOP)
OBJDIR   := obj_dir
BIN      := $(OBJDIR)/V$(TOP)
LOG      := sim.log
PASS_MSG := TEST RESULT: PASS
SOURCES  := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run check clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG)

check:
	@grep -q "^$(PASS_MSG)$$" $(LOG) && echo "log shows a pass" || (echo "log shows no pass"; exit 1)

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: rtl/ip_byte_if.sv
`timescale 1ns/100ps
`default_nettype none

interface ip_byte_if;

  logic        v;
  logic [7:0]  d;
  logic        sof;
  logic        eof;
  logic        err;
  // stable from sof to eof
  logic [7:0]  proto;
  logic [15:0] payload_length;

  modport src (
    output v, d, sof, eof, err, proto, payload_length
  );

  modport dst (
    input v, d, sof, eof, err, proto, payload_length
  );

endinterface

`default_nettype wire

// File: rtl/tcp_hdr_parser.sv
`timescale 1ns/100ps
`default_nettype none

module tcp_hdr_parser (
  input  logic                 clk,
  input  logic                 fsm_rst,
  ip_byte_if.dst               rx,
  input  logic [15:0]          local_port,
  tcp_opt_if.src               opt,
  output tcp_rx_pkg::tcp_hdr_t hdr,
  output logic                 hdr_v,
  output logic [15:0]          payload_length,
  output logic                 out_v,
  output logic [7:0]           out_d,
  output logic                 out_sof,
  output logic                 out_eof,
  output logic                 err
);

  tcp_rx_pkg::rx_state_e state;
  logic [15:0]      cnt;
  logic [15:0]      idx;
  logic [0:18][7:0] hdr_sr;
  logic [3:0]       off;
  logic [5:0]       hdr_end;
  logic             tcp_sof;
  logic             take;
  logic             off_ok;
  logic             at_hdr_end;
  logic             fwd;
  logic             err_seen;
  logic             err_acc;
  logic             first_pl;

  assign tcp_sof = rx.v && rx.sof && (rx.proto == tcp_rx_pkg::IP_PROTO_TCP);
  assign take    = tcp_sof || (rx.v && state != tcp_rx_pkg::RX_IDLE);
  // position of the current byte inside the tcp segment
  assign idx     = tcp_sof ? 16'd0 : cnt;
  assign hdr_end = {off, 2'b00} - 6'd1;
  assign off_ok  = off >= 4'd5;
  assign err_acc = (err_seen && !tcp_sof) || rx.err;

  // last byte of header plus options
  assign at_hdr_end = take && !tcp_sof && off_ok && (idx == {10'd0, hdr_end}) &&
                      (state == tcp_rx_pkg::RX_HEADER || state == tcp_rx_pkg::RX_OPTIONS);

  assign fwd = take && !tcp_sof && state == tcp_rx_pkg::RX_PAYLOAD &&
               hdr.dst_port == local_port;

  // options bytes go straight through to the options parser
  assign opt.v       = take && !tcp_sof && state == tcp_rx_pkg::RX_OPTIONS;
  assign opt.d       = rx.d;
  assign opt.first   = idx == 16'(tcp_rx_pkg::HDR_LEN);
  assign opt.last    = idx == {10'd0, hdr_end};
  assign opt.restart = tcp_sof;

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      state    <= tcp_rx_pkg::RX_IDLE;
      cnt      <= 16'd0;
      off      <= 4'd0;
      err_seen <= 1'b0;
      first_pl <= 1'b0;
      hdr_v    <= 1'b0;
      out_v    <= 1'b0;
      out_sof  <= 1'b0;
      out_eof  <= 1'b0;
      err      <= 1'b0;
    end else begin
      hdr_v   <= at_hdr_end;
      out_v   <= fwd;
      out_sof <= fwd && first_pl;
      out_eof <= fwd && rx.eof;
      err     <= 1'b0;
      if (at_hdr_end) first_pl <= 1'b1;
      if (take) begin
        cnt      <= idx + 16'd1;
        err_seen <= err_acc;
        if (tcp_sof) begin
          off   <= 4'd0;
          state <= tcp_rx_pkg::RX_HEADER;
        end else begin
          case (state)
            tcp_rx_pkg::RX_HEADER: begin
              if (idx == 16'd12) off <= rx.d[7:4];
              if (idx == 16'(tcp_rx_pkg::HDR_LEN - 1)) begin
                if (!off_ok) state <= tcp_rx_pkg::RX_DROP;
                else if (at_hdr_end) state <= tcp_rx_pkg::RX_PAYLOAD;
                else state <= tcp_rx_pkg::RX_OPTIONS;
              end
            end
            tcp_rx_pkg::RX_OPTIONS: begin
              if (at_hdr_end) state <= tcp_rx_pkg::RX_PAYLOAD;
            end
            tcp_rx_pkg::RX_PAYLOAD: begin
              first_pl <= 1'b0;
            end
            default: ;
          endcase
        end
        if (rx.eof) begin
          state <= tcp_rx_pkg::RX_IDLE;
          // byte count, sticky upstream error, bad data offset
          err   <= (idx + 16'd1 != rx.payload_length) || err_acc || tcp_sof || !off_ok;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take && idx < 16'(tcp_rx_pkg::HDR_LEN - 1)) hdr_sr <= {hdr_sr[1:18], rx.d};
    if (take && state == tcp_rx_pkg::RX_HEADER && off_ok &&
        idx == 16'(tcp_rx_pkg::HDR_LEN - 1)) begin
      hdr.src_port    <= {hdr_sr[0], hdr_sr[1]};
      hdr.dst_port    <= {hdr_sr[2], hdr_sr[3]};
      hdr.seq_num     <= {hdr_sr[4], hdr_sr[5], hdr_sr[6], hdr_sr[7]};
      hdr.ack_num     <= {hdr_sr[8], hdr_sr[9], hdr_sr[10], hdr_sr[11]};
      hdr.data_offset <= off;
      hdr.flags       <= {hdr_sr[12][0], hdr_sr[13]};
      hdr.win_size    <= {hdr_sr[14], hdr_sr[15]};
      hdr.checksum    <= {hdr_sr[16], hdr_sr[17]};
      hdr.urg_ptr     <= {hdr_sr[18], rx.d};
    end
    if (at_hdr_end) payload_length <= rx.payload_length - {10'd0, off, 2'b00};
    if (fwd) out_d <= rx.d;
  end

endmodule

`default_nettype wire

// File: rtl/tcp_opt_if.sv
`timescale 1ns/100ps
`default_nettype none

interface tcp_opt_if;

  logic       v;
  logic [7:0] d;
  logic       first;
  logic       last;
  // pulses on every tcp sof
  logic       restart;

  modport src (
    output v, d, first, last, restart
  );

  modport dst (
    input v, d, first, last, restart
  );

endinterface

`default_nettype wire

// File: rtl/tcp_opt_parser.sv
`timescale 1ns/100ps
`default_nettype none

module tcp_opt_parser (
  input  logic                  clk,
  input  logic                  fsm_rst,
  tcp_opt_if.dst                opt,
  output tcp_rx_pkg::tcp_opts_t opts
);

  tcp_rx_pkg::opt_state_e    state;
  tcp_rx_pkg::opt_state_e    cur;
  tcp_rx_pkg::tcp_opt_kind_e kind;
  logic [7:0]  len;
  logic [7:0]  left;
  // up to seven earlier data bytes, enough for the timestamp
  logic [55:0] sr;
  logic [63:0] val;
  logic [7:0]  done_len;
  logic        done;

  // the first options byte is always a kind byte
  assign cur = opt.first ? tcp_rx_pkg::OPT_KIND : state;
  assign val = {sr, opt.d};

  // option complete on this byte
  assign done = opt.v && ((cur == tcp_rx_pkg::OPT_LEN && opt.d == 8'd2) ||
                          (cur == tcp_rx_pkg::OPT_DATA && left == 8'd1));
  assign done_len = (cur == tcp_rx_pkg::OPT_LEN) ? opt.d : len;

  always_ff @(posedge clk) begin
    if (fsm_rst || opt.restart) begin
      state <= tcp_rx_pkg::OPT_KIND;
      opts  <= '0;
    end else if (opt.v) begin
      case (cur)
        tcp_rx_pkg::OPT_KIND: begin
          if (opt.d == tcp_rx_pkg::END) state <= tcp_rx_pkg::OPT_STOP;
          else if (opt.d == tcp_rx_pkg::NOP) state <= tcp_rx_pkg::OPT_KIND;
          else state <= tcp_rx_pkg::OPT_LEN;
        end
        tcp_rx_pkg::OPT_LEN: begin
          // a length below two cannot be walked past
          if (opt.d < 8'd2) state <= tcp_rx_pkg::OPT_STOP;
          else if (opt.d == 8'd2) state <= tcp_rx_pkg::OPT_KIND;
          else state <= tcp_rx_pkg::OPT_DATA;
        end
        tcp_rx_pkg::OPT_DATA: begin
          if (left == 8'd1) state <= tcp_rx_pkg::OPT_KIND;
        end
        default: ;
      endcase
      if (done) begin
        // known kinds count only with their fixed length
        case (kind)
          tcp_rx_pkg::MSS: begin
            if (done_len == 8'd4) begin
              opts.mss_pres <= 1'b1;
              opts.mss      <= val[15:0];
            end
          end
          tcp_rx_pkg::WSCALE: begin
            if (done_len == 8'd3) begin
              opts.wscale_pres <= 1'b1;
              opts.wscale      <= val[7:0];
            end
          end
          tcp_rx_pkg::SACK_PERM: begin
            if (done_len == 8'd2) opts.sack_perm_pres <= 1'b1;
          end
          tcp_rx_pkg::TSTAMP: begin
            if (done_len == 8'd10) begin
              opts.ts_pres <= 1'b1;
              opts.ts_val  <= val[63:32];
              opts.ts_ecr  <= val[31:0];
            end
          end
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (opt.v) begin
      if (cur == tcp_rx_pkg::OPT_KIND) kind <= tcp_rx_pkg::tcp_opt_kind_e'(opt.d);
      if (cur == tcp_rx_pkg::OPT_LEN) begin
        len  <= opt.d;
        left <= opt.d - 8'd2;
      end
      if (cur == tcp_rx_pkg::OPT_DATA) begin
        sr   <= val[55:0];
        left <= left - 8'd1;
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/tcp_rx_pkg.sv
`default_nettype none

package tcp_rx_pkg;

  // fixed tcp header, bytes
  localparam int HDR_LEN = 20;

  // protocol field of the ipv4 header
  localparam logic [7:0] IP_PROTO_TCP = 8'd6;

  typedef enum logic [7:0] {
    END       = 8'd0,
    NOP       = 8'd1,
    MSS       = 8'd2,
    WSCALE    = 8'd3,
    SACK_PERM = 8'd4,
    SACK      = 8'd5,
    TSTAMP    = 8'd8
  } tcp_opt_kind_e;

  typedef enum logic [1:0] {
    OPT_KIND,
    OPT_LEN,
    OPT_DATA,
    OPT_STOP
  } opt_state_e;

  typedef enum logic [2:0] {
    RX_IDLE,
    RX_HEADER,
    RX_OPTIONS,
    RX_PAYLOAD,
    RX_DROP
  } rx_state_e;

  typedef struct packed {
    logic [15:0] src_port;
    logic [15:0] dst_port;
    logic [31:0] seq_num;
    logic [31:0] ack_num;
    logic [3:0]  data_offset;
    // ns bit on top of the eight classic flags
    logic [8:0]  flags;
    logic [15:0] win_size;
    logic [15:0] checksum;
    logic [15:0] urg_ptr;
  } tcp_hdr_t;

  typedef struct packed {
    logic        mss_pres;
    logic [15:0] mss;
    logic        wscale_pres;
    logic [7:0]  wscale;
    logic        sack_perm_pres;
    logic        ts_pres;
    logic [31:0] ts_val;
    logic [31:0] ts_ecr;
  } tcp_opts_t;

endpackage

`default_nettype wire

// File: rtl/tcp_rx_top.sv
`timescale 1ns/100ps
`default_nettype none

module tcp_rx_top (
  input  logic        clk,
  input  logic        fsm_rst,
  input  logic        in_v,
  input  logic [7:0]  in_d,
  input  logic        in_sof,
  input  logic        in_eof,
  input  logic        in_err,
  input  logic [7:0]  in_proto,
  input  logic [15:0] in_payload_length,
  input  logic [15:0] local_port,
  output logic        hdr_v,
  output logic [15:0] src_port,
  output logic [15:0] dst_port,
  output logic [31:0] seq_num,
  output logic [31:0] ack_num,
  output logic [8:0]  flags,
  output logic [15:0] win_size,
  output logic [15:0] payload_length,
  output logic        mss_pres,
  output logic [15:0] mss,
  output logic        wscale_pres,
  output logic [7:0]  wscale,
  output logic        sack_perm_pres,
  output logic        ts_pres,
  output logic [31:0] ts_val,
  output logic [31:0] ts_ecr,
  output logic        out_v,
  output logic [7:0]  out_d,
  output logic        out_sof,
  output logic        out_eof,
  output logic        err
);

  tcp_rx_pkg::tcp_hdr_t  hdr;
  tcp_rx_pkg::tcp_opts_t opts;

  ip_byte_if rx_if ();
  tcp_opt_if opt_if ();

  assign rx_if.v              = in_v;
  assign rx_if.d              = in_d;
  assign rx_if.sof            = in_sof;
  assign rx_if.eof            = in_eof;
  assign rx_if.err            = in_err;
  assign rx_if.proto          = in_proto;
  assign rx_if.payload_length = in_payload_length;

  tcp_hdr_parser hdr_parser0 (
    .clk            (clk),
    .fsm_rst        (fsm_rst),
    .rx             (rx_if),
    .local_port     (local_port),
    .opt            (opt_if),
    .hdr            (hdr),
    .hdr_v          (hdr_v),
    .payload_length (payload_length),
    .out_v          (out_v),
    .out_d          (out_d),
    .out_sof        (out_sof),
    .out_eof        (out_eof),
    .err            (err)
  );

  tcp_opt_parser opt_parser0 (
    .clk     (clk),
    .fsm_rst (fsm_rst),
    .opt     (opt_if),
    .opts    (opts)
  );

  // header fields
  assign src_port = hdr.src_port;
  assign dst_port = hdr.dst_port;
  assign seq_num  = hdr.seq_num;
  assign ack_num  = hdr.ack_num;
  assign flags    = hdr.flags;
  assign win_size = hdr.win_size;

  // decoded options
  assign mss_pres       = opts.mss_pres;
  assign mss            = opts.mss;
  assign wscale_pres    = opts.wscale_pres;
  assign wscale         = opts.wscale;
  assign sack_perm_pres = opts.sack_perm_pres;
  assign ts_pres        = opts.ts_pres;
  assign ts_val         = opts.ts_val;
  assign ts_ecr         = opts.ts_ecr;

endmodule

`default_nettype wire

// File: tb.f
rtl/tcp_rx_pkg.sv
rtl/ip_byte_if.sv
rtl/tcp_opt_if.sv
rtl/tcp_hdr_parser.sv
rtl/tcp_opt_parser.sv
rtl/tcp_rx_top.sv
verif/tb_clkgen.sv
verif/tb_tcp_rx.sv

// File: verif/tb_clkgen.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clkgen (
  output logic clk,
  output logic fsm_rst
);

  // 8 ns period
  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // reset held over three rising edges
  initial begin
    fsm_rst = 1'b1;
    repeat (3) @(posedge clk);
    #1;
    fsm_rst = 1'b0;
  end

endmodule

`default_nettype wire

// File: verif/tb_tcp_rx.sv
`timescale 1ns/100ps
`default_nettype none

module tb_tcp_rx;

  localparam logic [15:0] LOCAL_PORT = 16'h1f90;
  localparam int SEED          = 5931;
  localparam int NUM_SEGS      = 14;
  // longest segment is the full option list plus its payload
  localparam int MAX_SEG_BYTES = 56;
  localparam int MAX_GAP       = 3;
  localparam int CYCLE_LIMIT   = NUM_SEGS * (MAX_SEG_BYTES * (MAX_GAP + 1) + 2) + 100;

  logic clk, fsm_rst;
  logic in_v, in_sof, in_eof, in_err;
  logic [7:0] in_d, in_proto;
  logic [15:0] in_payload_length, local_port;
  logic hdr_v, mss_pres, wscale_pres, sack_perm_pres, ts_pres;
  logic out_v, out_sof, out_eof, err;
  logic [15:0] src_port, dst_port, win_size, payload_length, mss;
  logic [31:0] seq_num, ack_num, ts_val, ts_ecr;
  logic [8:0] flags;
  logic [7:0] wscale, out_d;

  // expected header and options of the segment in flight
  logic [15:0] exp_src, exp_dst, exp_win, exp_plen;
  logic [31:0] exp_seq, exp_ack;
  logic [8:0] exp_flags;
  tcp_rx_pkg::tcp_opts_t exp_opts;
  logic [7:0] opt_q[$];

  // per byte expectation delayed one cycle to line up with the DUT
  logic exp_hdr_v, exp_out_v, exp_out_sof, exp_out_eof, exp_err;
  logic [7:0] exp_out_d;
  logic exp_hdr_v_q, exp_out_v_q, exp_out_sof_q, exp_out_eof_q, exp_err_q;
  logic [7:0] exp_out_d_q;

  int field_errors = 0;
  int pulse_errors = 0;
  int cycles = 0;
  int gap_max = 0;

  tb_clkgen clkgen0 (.clk(clk), .fsm_rst(fsm_rst));

  tcp_rx_top dut0 (.*);

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      exp_hdr_v_q   <= 1'b0;
      exp_out_v_q   <= 1'b0;
      exp_out_sof_q <= 1'b0;
      exp_out_eof_q <= 1'b0;
      exp_err_q     <= 1'b0;
    end else begin
      exp_hdr_v_q   <= exp_hdr_v;
      exp_out_v_q   <= exp_out_v;
      exp_out_sof_q <= exp_out_sof;
      exp_out_eof_q <= exp_out_eof;
      exp_err_q     <= exp_err;
    end
    exp_out_d_q <= exp_out_d;
  end

  assert property (@(posedge clk) disable iff (fsm_rst)
    hdr_v |-> (src_port == exp_src && dst_port == exp_dst && seq_num == exp_seq &&
               ack_num == exp_ack && flags == exp_flags && win_size == exp_win &&
               payload_length == exp_plen))
    else begin
      field_errors++;
      $display("Error: %0t header fields differ from the segment sent", $time);
    end

  assert property (@(posedge clk) disable iff (fsm_rst)
    hdr_v |-> ({mss_pres, mss, wscale_pres, wscale, sack_perm_pres, ts_pres,
                ts_val, ts_ecr} == exp_opts))
    else begin
      field_errors++;
      $display("Error: %0t decoded options differ from the option list", $time);
    end

  assert property (@(posedge clk) disable iff (fsm_rst)
    out_v |-> (out_d == exp_out_d_q && out_sof == exp_out_sof_q && out_eof == exp_out_eof_q))
    else begin
      field_errors++;
      $display("Error: %0t payload byte %h sof %b eof %b, expected %h sof %b eof %b",
               $time, out_d, out_sof, out_eof, exp_out_d_q, exp_out_sof_q, exp_out_eof_q);
    end

  // pulses only where the frame rules put them
  always @(negedge clk) begin
    if (!fsm_rst) begin
      assert (hdr_v == exp_hdr_v_q) else begin
        pulse_errors++;
        $display("Error: %0t hdr_v is %b, expected %b", $time, hdr_v, exp_hdr_v_q);
      end
      assert (out_v == exp_out_v_q) else begin
        pulse_errors++;
        $display("Error: %0t out_v is %b, expected %b", $time, out_v, exp_out_v_q);
      end
      assert (err == exp_err_q) else begin
        pulse_errors++;
        $display("Error: %0t err is %b, expected %b", $time, err, exp_err_q);
      end
      assert (out_v || !(out_sof || out_eof)) else begin
        pulse_errors++;
        $display("Error: %0t out_sof or out_eof high without out_v", $time);
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > CYCLE_LIMIT) begin
      $display("simulation ran past %0d cycles without finishing the tests", CYCLE_LIMIT);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  // appends the low cnt bytes of b with the first byte leftmost
  task automatic add_option(input logic [95:0] b, input int cnt);
    int k;
    for (k = cnt - 1; k >= 0; k--) opt_q.push_back(b[k*8 +: 8]);
  endtask

  // walks the options area by kind and length
  function automatic void decode_opts();
    int i;
    int l;
    logic [7:0] kd;
    exp_opts = '0;
    i = 0;
    while (i < opt_q.size() && opt_q[i] != 8'd0) begin
      kd = opt_q[i];
      if (kd == 8'd1) begin
        i = i + 1;
      end else begin
        if (i + 1 >= opt_q.size()) break;
        l = int'(opt_q[i + 1]);
        // option cut off by the end of the area or a length that cannot be walked
        if (l < 2 || i + l > opt_q.size()) break;
        if (kd == tcp_rx_pkg::MSS && l == 4) begin
          exp_opts.mss_pres = 1'b1;
          exp_opts.mss      = {opt_q[i + 2], opt_q[i + 3]};
        end
        if (kd == tcp_rx_pkg::WSCALE && l == 3) begin
          exp_opts.wscale_pres = 1'b1;
          exp_opts.wscale      = opt_q[i + 2];
        end
        if (kd == tcp_rx_pkg::SACK_PERM && l == 2) exp_opts.sack_perm_pres = 1'b1;
        if (kd == tcp_rx_pkg::TSTAMP && l == 10) begin
          exp_opts.ts_pres = 1'b1;
          exp_opts.ts_val  = {opt_q[i + 2], opt_q[i + 3], opt_q[i + 4], opt_q[i + 5]};
          exp_opts.ts_ecr  = {opt_q[i + 6], opt_q[i + 7], opt_q[i + 8], opt_q[i + 9]};
        end
        i = i + l;
      end
    end
  endfunction

  task automatic idle_cycle();
    @(posedge clk);
    #1;
    in_v        = 1'b0;
    in_sof      = 1'b0;
    in_eof      = 1'b0;
    in_err      = 1'b0;
    exp_hdr_v   = 1'b0;
    exp_out_v   = 1'b0;
    exp_out_sof = 1'b0;
    exp_out_eof = 1'b0;
    exp_err     = 1'b0;
  endtask

  // builds one segment around opt_q and drives it byte by byte
  task automatic send_segment(input logic [15:0] dport, input int pay_len,
                              input logic [7:0] proto, input int len_adj,
                              input int err_at, input int off_force);
    logic [7:0] seg[$];
    logic [159:0] h;
    logic [8:0] fl;
    int off;
    int n;
    int hend;
    int k;
    bit tcp;
    bit fwd;
    bit bad;
    off = (off_force >= 0) ? off_force : 5 + (opt_q.size() + 3) / 4;
    // pad with END up to the offset
    while (opt_q.size() < off * 4 - 20) opt_q.push_back(8'h00);
    exp_src   = 16'($urandom);
    exp_dst   = dport;
    exp_seq   = $urandom;
    exp_ack   = $urandom;
    fl        = 9'($urandom);
    exp_flags = fl;
    exp_win   = 16'($urandom);
    h = {exp_src, dport, exp_seq, exp_ack, 4'(off), 3'b000, fl, exp_win,
         16'($urandom), 16'($urandom)};
    for (k = 19; k >= 0; k--) seg.push_back(h[k*8 +: 8]);
    for (k = 0; k < opt_q.size(); k++) seg.push_back(opt_q[k]);
    for (k = 0; k < pay_len; k++) seg.push_back(8'($urandom));
    n    = seg.size();
    hend = off * 4 - 1;
    tcp  = (proto == tcp_rx_pkg::IP_PROTO_TCP);
    bad  = (len_adj != 0) || (err_at >= 0) || (off < 5);
    exp_plen = 16'(n + len_adj - off * 4);
    decode_opts();
    in_proto          = proto;
    in_payload_length = 16'(n + len_adj);
    for (k = 0; k < n; k++) begin
      repeat ($urandom_range(gap_max, 0)) idle_cycle();
      @(posedge clk);
      #1;
      in_v   = 1'b1;
      in_d   = seg[k];
      in_sof = (k == 0);
      in_eof = (k == n - 1);
      in_err = (k == err_at);
      fwd    = tcp && off >= 5 && k > hend && dport == LOCAL_PORT;
      exp_hdr_v   = tcp && off >= 5 && k == hend;
      exp_out_v   = fwd;
      exp_out_d   = seg[k];
      exp_out_sof = fwd && (k == hend + 1);
      exp_out_eof = fwd && (k == n - 1);
      exp_err     = tcp && (k == n - 1) && bad;
    end
    // keep this segment's expectations until its last checks are done
    repeat (2) idle_cycle();
    opt_q.delete();
  endtask

  initial begin
    int r;
    void'($urandom(SEED));
    in_v = 1'b0;
    in_d = 8'h00;
    in_sof = 1'b0;
    in_eof = 1'b0;
    in_err = 1'b0;
    in_proto = 8'h00;
    in_payload_length = 16'h0000;
    local_port = LOCAL_PORT;
    exp_hdr_v = 1'b0;
    exp_out_v = 1'b0;
    exp_out_sof = 1'b0;
    exp_out_eof = 1'b0;
    exp_err = 1'b0;
    exp_out_d = 8'h00;
    exp_opts = '0;
    @(negedge fsm_rst);

    send_segment(LOCAL_PORT, 12, tcp_rx_pkg::IP_PROTO_TCP, 0, -1, -1);
    // nop, mss, wscale, sack permitted, unknown kind 30, timestamp
    add_option(96'h01, 1);
    add_option(96'h020405b4, 4);
    add_option(96'h030307, 3);
    add_option(96'h0402, 2);
    add_option(96'h1e0611223344, 6);
    add_option(96'h080adeadbeef01020304, 10);
    send_segment(LOCAL_PORT, 8, tcp_rx_pkg::IP_PROTO_TCP, 0, -1, -1);
    // END ahead of the timestamp
    add_option(96'h02040218, 4);
    add_option(96'h0100, 2);
    add_option(96'h080a0a0b0c0d0e0f1011, 10);
    send_segment(LOCAL_PORT, 5, tcp_rx_pkg::IP_PROTO_TCP, 0, -1, -1);
    // mss with length six
    add_option(96'h020605b40000, 6);
    add_option(96'h03030e, 3);
    send_segment(LOCAL_PORT, 4, tcp_rx_pkg::IP_PROTO_TCP, 0, -1, -1);

    send_segment(LOCAL_PORT ^ 16'h0100, 10, tcp_rx_pkg::IP_PROTO_TCP, 0, -1, -1);
    // udp frame with a bad length and an upstream error
    send_segment(LOCAL_PORT, 16, 8'd17, 3, 22, -1);

    send_segment(LOCAL_PORT, 8, tcp_rx_pkg::IP_PROTO_TCP, 3, -1, -1);
    send_segment(LOCAL_PORT, 8, tcp_rx_pkg::IP_PROTO_TCP, 0, 25, -1);
    send_segment(LOCAL_PORT, 6, tcp_rx_pkg::IP_PROTO_TCP, 0, -1, 4);

    gap_max = MAX_GAP;
    send_segment(LOCAL_PORT, 0, tcp_rx_pkg::IP_PROTO_TCP, 0, -1, -1);
    for (r = 0; r < 4; r++) begin
      if (r % 2 == 1) add_option(96'h0402030309, 5);
      send_segment(LOCAL_PORT, int'($urandom_range(24, 1)), tcp_rx_pkg::IP_PROTO_TCP,
                   0, -1, -1);
    end
    repeat (4) idle_cycle();

    $display("errors: %0d field, %0d pulse", field_errors, pulse_errors);
    if (field_errors == 0 && pulse_errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
